//--- cdc_dst_receiver.sv
`timescale 1ns/1ps

module cdc_dst_receiver (
    input  logic                 clk_dst,
    input  logic                 rst_dst,
    input  logic                 rx_valid,
    input  cdc_pkg::data_frame_t rx_frame,
    output logic                 out_valid,
    output cdc_pkg::data_word_t  out_data,
    output cdc_pkg::seq_t        out_seq,
    input  logic                 out_ready,
    output logic                 echo_valid,
    output cdc_pkg::ack_frame_t  echo_frame,
    input  logic                 echo_ready
);

    import cdc_pkg::*;

    typedef enum logic [1:0] {
        GET_DATA,
        PRESENT,
        SEND_ECHO
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   load;
    logic   taken;
    logic   echoed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign out_valid  = (state == PRESENT);
    assign echo_valid = (state == SEND_ECHO);

    assign load   = (state == GET_DATA) && rx_valid;
    assign taken  = out_valid && out_ready;
    assign echoed = echo_valid && echo_ready;

    assign echo_frame.seq = out_seq;        // Held until the next load

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            GET_DATA: begin
                if (load) begin
                    state_nxt = PRESENT;
                end
            end
            PRESENT: begin
                if (taken) begin
                    state_nxt = SEND_ECHO;
                end
            end
            SEND_ECHO: begin
                if (echoed) begin
                    state_nxt = GET_DATA;   // Ready for the next word
                end
            end
            default: begin
                state_nxt = GET_DATA;
            end
        endcase
    end

    always_ff @(posedge clk_dst) begin
        if (rst_dst) begin
            state <= GET_DATA;
        end else begin
            state <= state_nxt;
        end
    end

    // Output word, stable from load until the echo has gone out
    always_ff @(posedge clk_dst) begin
        if (load) begin
            out_data <= rx_frame.data;
            out_seq  <= rx_frame.seq;
        end
    end

endmodule

//--- cdc_handshake_props.sv
`timescale 1ns/1ps

module cdc_handshake_props (
    input logic                clk_src,
    input logic                rst_src,
    input logic                clk_dst,
    input logic                rst_dst,
    input logic                in_valid,
    input logic                in_ready,
    input logic                done,
    input logic                out_valid,
    input cdc_pkg::data_word_t out_data,
    input cdc_pkg::seq_t       out_seq,
    input logic                out_ready
);

    import cdc_pkg::*;

    int   src_fails = 0;
    int   dst_fails = 0;
    logic in_flight;    // Word accepted, echo not yet matched
    seq_t next_seq;     // Tag the next delivered word must carry

    always_ff @(posedge clk_src) begin
        if (rst_src) begin
            in_flight <= 1'b0;
        end else if (in_valid && in_ready) begin
            in_flight <= 1'b1;
        end else if (done) begin
            in_flight <= 1'b0;
        end
    end

    always_ff @(posedge clk_dst) begin
        if (rst_dst) begin
            next_seq <= '0;
        end else if (out_valid && out_ready) begin
            next_seq <= next_seq + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Source domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    src_reset_a: assert property (@(posedge clk_src) rst_src |=> in_ready && !done)
        else begin
            $error("in_ready low or done high right after source reset");
            src_fails = src_fails + 1;
        end

    done_pulse_a: assert property (@(posedge clk_src) disable iff (rst_src) done |=> !done)
        else begin
            $error("done held high for more than one cycle");
            src_fails = src_fails + 1;
        end

    one_in_flight_a: assert property (@(posedge clk_src) disable iff (rst_src)
        in_flight && !done |-> !in_ready)
        else begin
            $error("in_ready high while a word is still in flight");
            src_fails = src_fails + 1;
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Destination domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dst_reset_a: assert property (@(posedge clk_dst) rst_dst |=> !out_valid)
        else begin
            $error("out_valid high right after destination reset");
            dst_fails = dst_fails + 1;
        end

    out_stable_a: assert property (@(posedge clk_dst) disable iff (rst_dst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_seq))
        else begin
            $error("output word changed while stalled by out_ready");
            dst_fails = dst_fails + 1;
        end

    seq_order_a: assert property (@(posedge clk_dst) disable iff (rst_dst)
        out_valid |-> out_seq == next_seq)
        else begin
            $error("out_seq is not one above the last delivered tag");
            dst_fails = dst_fails + 1;
        end

endmodule

//--- cdc_handshake_top.sv
`timescale 1ns/1ps

module cdc_handshake_top (
    input  logic                clk_src,
    input  logic                rst_src,
    input  logic                clk_dst,
    input  logic                rst_dst,
    input  logic                in_valid,
    input  cdc_pkg::data_word_t in_data,
    output logic                in_ready,
    output logic                done,
    output logic                out_valid,
    output cdc_pkg::data_word_t out_data,
    output cdc_pkg::seq_t       out_seq,
    input  logic                out_ready
);

    import cdc_pkg::*;

    logic        send_valid;
    logic        send_ready;
    data_frame_t send_frame;
    logic        rx_valid;
    data_frame_t rx_frame;
    logic        echo_valid;
    logic        echo_ready;
    ack_frame_t  echo_frame;
    logic        ack_valid;
    ack_frame_t  ack_frame;

    cdc_src_sender u_sender (
        .clk_src    (clk_src),
        .rst_src    (rst_src),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .done       (done),
        .send_valid (send_valid),
        .send_frame (send_frame),
        .send_ready (send_ready),
        .ack_valid  (ack_valid),
        .ack_frame  (ack_frame)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Crossings, forward and return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    cdc_word_sync #(.payload_t(data_frame_t)) u_data_sync (
        .clk_src   (clk_src),
        .rst_src   (rst_src),
        .clk_dst   (clk_dst),
        .rst_dst   (rst_dst),
        .src_valid (send_valid),
        .src_frame (send_frame),
        .src_ready (send_ready),
        .dst_valid (rx_valid),
        .dst_frame (rx_frame)
    );

    cdc_word_sync #(.payload_t(ack_frame_t)) u_ack_sync (
        .clk_src   (clk_dst),                  // Receiver side launches
        .rst_src   (rst_dst),
        .clk_dst   (clk_src),
        .rst_dst   (rst_src),
        .src_valid (echo_valid),
        .src_frame (echo_frame),
        .src_ready (echo_ready),
        .dst_valid (ack_valid),
        .dst_frame (ack_frame)
    );

    cdc_dst_receiver u_receiver (
        .clk_dst    (clk_dst),
        .rst_dst    (rst_dst),
        .rx_valid   (rx_valid),
        .rx_frame   (rx_frame),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_seq    (out_seq),
        .out_ready  (out_ready),
        .echo_valid (echo_valid),
        .echo_frame (echo_frame),
        .echo_ready (echo_ready)
    );

endmodule

//--- cdc_pkg.sv
`include "cdc_settings.svh"

package cdc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scalar types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`CDC_DATA_WIDTH-1:0] data_word_t;
    typedef logic [`CDC_SEQ_WIDTH-1:0]  seq_t;    // Wraps after 2**width words

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frames carried by the two synchronizers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Forward direction, source to destination
    typedef struct packed {
        seq_t       seq;    // Upper byte
        data_word_t data;
    } data_frame_t;

    // Return direction, destination to source
    typedef struct packed {
        seq_t seq;          // Copy of the delivered word's tag
    } ack_frame_t;

endpackage

//--- cdc_settings.svh
`ifndef CDC_SETTINGS_SVH
`define CDC_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word crossing widths and depths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CDC_DATA_WIDTH  32  // Client data word

`define CDC_SEQ_WIDTH   8   // Tag sent with each word and echoed back

`define CDC_SYNC_STAGES 2   // Flops per toggle synchronizer, 2 or more

`endif

//--- cdc_src_sender.sv
`timescale 1ns/1ps

module cdc_src_sender (
    input  logic                 clk_src,
    input  logic                 rst_src,
    input  logic                 in_valid,
    input  cdc_pkg::data_word_t  in_data,
    output logic                 in_ready,
    output logic                 done,
    output logic                 send_valid,
    output cdc_pkg::data_frame_t send_frame,
    input  logic                 send_ready,
    input  logic                 ack_valid,
    input  cdc_pkg::ack_frame_t  ack_frame
);

    import cdc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_ACK
    } state_t;

    state_t state;
    state_t state_nxt;
    seq_t   seq_q;      // Tag for the word in flight
    logic   accept;
    logic   sent;
    logic   ack_match;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_ready   = (state == IDLE);
    assign send_valid = (state == SEND);

    assign accept    = in_valid && in_ready;
    assign sent      = send_valid && send_ready;
    assign ack_match = (state == WAIT_ACK) && ack_valid && (ack_frame.seq == seq_q);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                if (sent) begin
                    state_nxt = WAIT_ACK;     // Frame is now in the synchronizer
                end
            end
            WAIT_ACK: begin
                if (ack_match) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_src) begin
        if (rst_src) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Stale or foreign echoes fall through without effect
    always_ff @(posedge clk_src) begin
        if (rst_src) begin
            done  <= 1'b0;
            seq_q <= '0;
        end else begin
            done <= ack_match;
            if (ack_match) begin
                seq_q <= seq_q + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outgoing frame
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_src) begin
        if (accept) begin
            send_frame.seq  <= seq_q;
            send_frame.data <= in_data;
        end
    end

endmodule

//--- cdc_word_sync.sv
`timescale 1ns/1ps
`include "cdc_settings.svh"

module cdc_word_sync #(
    parameter type payload_t = logic
) (
    input  logic     clk_src,
    input  logic     rst_src,
    input  logic     clk_dst,
    input  logic     rst_dst,
    input  logic     src_valid,
    input  payload_t src_frame,
    output logic     src_ready,
    output logic     dst_valid,
    output payload_t dst_frame
);

    localparam int LAST = `CDC_SYNC_STAGES - 1;

    payload_t                    frame_q;   // Held stable for the whole crossing
    logic                        busy;
    logic                        req_tgl;
    logic [`CDC_SYNC_STAGES-1:0] ack_sync;
    logic                        ack_seen;
    logic                        ack_edge;
    logic                        accept;

    logic [`CDC_SYNC_STAGES-1:0] req_sync;
    logic                        req_seen;
    logic                        req_edge;
    logic                        ack_tgl;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Source domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign src_ready = !busy;
    assign accept    = src_valid && !busy;
    assign ack_edge  = ack_sync[LAST] ^ ack_seen;

    always_ff @(posedge clk_src) begin
        if (rst_src) begin
            busy     <= 1'b0;
            req_tgl  <= 1'b0;
            ack_sync <= '0;
            ack_seen <= 1'b0;
        end else begin
            ack_sync <= {ack_sync[LAST-1:0], ack_tgl};
            ack_seen <= ack_sync[LAST];
            if (accept) begin
                busy    <= 1'b1;
                req_tgl <= ~req_tgl;      // Launch the request
            end else if (ack_edge) begin
                busy    <= 1'b0;          // Crossing finished, re-arm
            end
        end
    end

    always_ff @(posedge clk_src) begin
        if (accept) begin
            frame_q <= src_frame;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Destination domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_edge = req_sync[LAST] ^ req_seen;

    always_ff @(posedge clk_dst) begin
        if (rst_dst) begin
            req_sync  <= '0;
            req_seen  <= 1'b0;
            ack_tgl   <= 1'b0;
            dst_valid <= 1'b0;
        end else begin
            req_sync  <= {req_sync[LAST-1:0], req_tgl};
            req_seen  <= req_sync[LAST];
            dst_valid <= req_edge;        // One cycle per request
            if (req_edge) begin
                ack_tgl <= ~ack_tgl;
            end
        end
    end

    // frame_q has been stable for at least the synchronizer depth here
    always_ff @(posedge clk_dst) begin
        if (req_edge) begin
            dst_frame <= frame_q;
        end
    end

endmodule

//--- filelist.f
+incdir+.
cdc_pkg.sv
cdc_word_sync.sv
cdc_src_sender.sv
cdc_dst_receiver.sv
cdc_handshake_top.sv
cdc_handshake_props.sv
tb_cdc_handshake.sv

//--- run.sh
#!/bin/sh
# Build the handshake crossing testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cdc_handshake -f filelist.f &&
./obj_dir/Vtb_cdc_handshake +verilator+error+limit+1000 | tee /dev/stderr |
    grep -x "PASS: all tests" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tb_cdc_handshake.sv
`timescale 1ns/1ps

module tb_cdc_handshake;

    import cdc_pkg::*;

    localparam int NUM_WORDS    = 300;  // Enough to wrap the 8-bit tag
    localparam int STALL_AT     = 150;
    localparam int STALL_CYCLES = 200;
    localparam int WAIT_LIMIT   = 1000;

    logic       clk_src;
    logic       rst_src;
    logic       clk_dst;
    logic       rst_dst;
    logic       in_valid;
    data_word_t in_data;
    logic       in_ready;
    logic       done;
    logic       out_valid;
    data_word_t out_data;
    seq_t       out_seq;
    logic       out_ready;

    data_word_t pending_words[$];   // Accepted but not yet delivered
    int         delivered = 0;
    int         done_count = 0;
    int         mismatch_errors = 0;
    int         other_errors = 0;
    int         monitor_errors = 0;
    logic       timed_out = 1'b0;
    logic       stall_on = 1'b0;

    cdc_handshake_top uut (
        .clk_src   (clk_src),
        .rst_src   (rst_src),
        .clk_dst   (clk_dst),
        .rst_dst   (rst_dst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .done      (done),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_seq   (out_seq),
        .out_ready (out_ready)
    );

    bind cdc_handshake_top cdc_handshake_props u_props (
        .clk_src   (clk_src),
        .rst_src   (rst_src),
        .clk_dst   (clk_dst),
        .rst_dst   (rst_dst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .done      (done),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_seq   (out_seq),
        .out_ready (out_ready)
    );

    initial begin
        clk_src = 1'b0;
        forever #13 clk_src = ~clk_src;     // Unrelated to clk_dst
    end

    initial begin
        clk_dst = 1'b0;
        forever #20 clk_dst = ~clk_dst;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name,
                     expected, actual);
            mismatch_errors = mismatch_errors + 1;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        other_errors = other_errors + 1;
        timed_out = 1'b1;
    endtask

    // Source side during the long stall and the done tally
    always @(posedge clk_src) begin
        if (!rst_src && done) begin
            done_count = done_count + 1;
        end
        if (stall_on && in_ready) begin
            $display("MISMATCH at %0t: in_ready expected 0, got 1", $time);
            monitor_errors = monitor_errors + 1;
        end
        if (stall_on && done) begin
            $display("MISMATCH at %0t: done expected 0, got 1", $time);
            monitor_errors = monitor_errors + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_source();
        int         n;
        int         waited;
        data_word_t word;
        for (n = 0; n < NUM_WORDS && !timed_out; n = n + 1) begin
            repeat ($urandom_range(2, 0)) @(posedge clk_src);   // Idle gap
            word = $urandom;
            @(posedge clk_src);
            in_valid <= 1'b1;
            in_data  <= word;
            waited = 0;
            @(posedge clk_src);
            while (!in_ready && !timed_out) begin
                waited = waited + 1;
                if (waited > WAIT_LIMIT) begin
                    report_timeout("in_ready");
                end else begin
                    @(posedge clk_src);
                end
            end
            if (!timed_out) begin
                pending_words.push_back(word);  // Taken on this edge
            end
            in_valid <= 1'b0;
        end
    endtask

    task automatic hold_back_pressure();
        int         waited;
        data_word_t held;
        out_ready <= 1'b0;
        waited = 0;
        @(posedge clk_dst);
        while (!out_valid && !timed_out) begin
            waited = waited + 1;
            if (waited > WAIT_LIMIT) begin
                report_timeout("a word to stall on");
            end else begin
                @(posedge clk_dst);
            end
        end
        if (!timed_out) begin
            held = out_data;
            stall_on = 1'b1;
            repeat (STALL_CYCLES) begin
                @(posedge clk_dst);
                check_value("out_valid", 32'(1'b1), 32'(out_valid));
                check_value("out_data", held, out_data);
            end
            stall_on = 1'b0;
        end
        out_ready <= 1'b1;
    endtask

    task automatic consume_dest();
        int         idle;
        seq_t       exp_seq;
        data_word_t exp_word;
        logic       stalled;
        idle = 0;
        exp_seq = '0;
        stalled = 1'b0;
        while (delivered < NUM_WORDS && !timed_out) begin
            @(posedge clk_dst);
            if (out_valid && out_ready) begin
                if (pending_words.size() == 0) begin
                    $display("ERROR at %0t: word delivered with none pending", $time);
                    other_errors = other_errors + 1;
                end else begin
                    exp_word = pending_words.pop_front();
                    check_value("out_data", exp_word, out_data);
                end
                check_value("out_seq", 32'(exp_seq), 32'(out_seq));
                exp_seq = exp_seq + 1'b1;
                delivered = delivered + 1;
                idle = 0;
            end else if (idle > WAIT_LIMIT) begin
                report_timeout("a word at the consumer");
            end else begin
                idle = idle + 1;
            end
            if (delivered == STALL_AT && !stalled) begin
                stalled = 1'b1;
                hold_back_pressure();
            end else begin
                out_ready <= ($urandom_range(3, 0) != 0);   // Ready about 3 in 4
            end
        end
    endtask

    initial begin : main
        int waited;
        int assert_fails;
        void'($urandom(92));
        in_valid  <= 1'b0;
        in_data   <= '0;
        out_ready <= 1'b0;
        rst_src   <= 1'b1;
        rst_dst   <= 1'b1;
        fork
            begin
                repeat (10) @(posedge clk_src);
                rst_src <= 1'b0;
            end
            begin
                repeat (10) @(posedge clk_dst);
                rst_dst <= 1'b0;
            end
        join
        @(negedge clk_src);
        check_value("in_ready", 32'(1'b1), 32'(in_ready));
        check_value("done", 32'(1'b0), 32'(done));
        @(negedge clk_dst);
        check_value("out_valid", 32'(1'b0), 32'(out_valid));
        fork
            drive_source();
            consume_dest();
        join
        waited = 0;
        while (done_count < NUM_WORDS && !timed_out) begin
            @(negedge clk_src);
            waited = waited + 1;
            if (waited > WAIT_LIMIT) begin
                report_timeout("the last done pulse");
            end
        end
        check_value("done pulse count", 32'(delivered), 32'(done_count));
        assert_fails = uut.u_props.src_fails + uut.u_props.dst_fails;
        $display("Summary: %0d mismatches, %0d other, %0d monitor, %0d assertion failures",
                 mismatch_errors, other_errors, monitor_errors, assert_fails);
        if (mismatch_errors + other_errors + monitor_errors + assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
